// ==== filelist.f ====
rtl/lpif_pkg.sv
rtl/lane_if.sv
rtl/link_sync.sv
rtl/flit_pack.sv
rtl/phy_lane.sv
rtl/flit_unpack.sv
rtl/lpif_bridge_top.sv
tests/tb_lpif_checks.sv
tests/tb_lpif_bridge.sv

// ==== Bender.yml ====
package:
  name: lpif_bridge

sources:
  - rtl/lpif_pkg.sv
  - rtl/lane_if.sv
  - rtl/link_sync.sv
  - rtl/flit_pack.sv
  - rtl/phy_lane.sv
  - rtl/flit_unpack.sv
  - rtl/lpif_bridge_top.sv
  - target: test
    files:
      - tests/tb_lpif_checks.sv
      - tests/tb_lpif_bridge.sv

// ==== tests/tb_lpif_bridge.sv ====
`timescale 1ns/100ps

module tb_lpif_bridge
  import lpif_pkg::*;
();

  localparam int NUM_LANES      = 4;
  localparam int DX             = 5;
  localparam int DY             = 3;
  localparam int DZ             = 7;
  localparam int LATENCY        = 4;
  localparam int TIMEOUT_CYCLES = 2000;

  typedef struct {
    lpif_flit_t flit;
    int         cycle;
  } sb_entry_t;

  logic                             clk_wr = 1'b0;
  logic                             rst_n;
  logic                             tx_online;
  logic                             rx_online;
  logic [DELAY_W-1:0]               delay_x_value;
  logic [DELAY_W-1:0]               delay_y_value;
  logic [DELAY_W-1:0]               delay_z_value;
  logic [NUM_LANES-1:0][LANE_W-1:0] tx_phy;
  logic [NUM_LANES-1:0][LANE_W-1:0] rx_phy;
  lpif_flit_t                       drv_flit;
  lpif_flit_t                       ustrm_flit;
  lpif_flit_t                       exp_flit;
  logic                             exp_due;
  logic [31:0]                      tx_dbg;
  logic [31:0]                      rx_dbg;
  int                               cycle = 0;
  int                               value_errors;
  int                               seq_errors;
  sb_entry_t                        sb_q[$];

  always #50 clk_wr = ~clk_wr;

  always @(posedge clk_wr) begin
    cycle <= cycle + 1;
  end

  // PHY loopback
  assign rx_phy = tx_phy;

  lpif_bridge_top #(.NUM_LANES(NUM_LANES)) dut (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .dstrm_state                (drv_flit.state),
    .dstrm_protid               (drv_flit.protid),
    .dstrm_data                 (drv_flit.data),
    .dstrm_dvalid               (drv_flit.dvalid),
    .dstrm_crc                  (drv_flit.crc),
    .dstrm_crc_valid            (drv_flit.crc_valid),
    .dstrm_valid                (drv_flit.valid),
    .ustrm_state                (ustrm_flit.state),
    .ustrm_protid               (ustrm_flit.protid),
    .ustrm_data                 (ustrm_flit.data),
    .ustrm_dvalid               (ustrm_flit.dvalid),
    .ustrm_crc                  (ustrm_flit.crc),
    .ustrm_crc_valid            (ustrm_flit.crc_valid),
    .ustrm_valid                (ustrm_flit.valid),
    .tx_downstream_debug_status (tx_dbg),
    .rx_upstream_debug_status   (rx_dbg)
  );

  tb_lpif_checks #(.NUM_LANES(NUM_LANES), .DX(DX), .DY(DY), .DZ(DZ)) checks (
    .clk_wr       (clk_wr),
    .rst_n        (rst_n),
    .tx_online    (tx_online),
    .rx_online    (rx_online),
    .tx_phy       (tx_phy),
    .ustrm_flit   (ustrm_flit),
    .tx_dbg       (tx_dbg),
    .rx_dbg       (rx_dbg),
    .exp_due      (exp_due),
    .exp_flit     (exp_flit),
    .value_errors (value_errors),
    .seq_errors   (seq_errors)
  );

  function automatic lpif_flit_t random_flit();
    lpif_flit_t f;
    f.state     = STATE_W'($urandom);
    f.protid    = PROTID_W'($urandom);
    f.data      = {$urandom, $urandom, $urandom, $urandom};
    f.dvalid    = $urandom_range(1);
    f.crc       = CRC_W'($urandom);
    f.crc_valid = $urandom_range(1);
    f.valid     = $urandom_range(1);
    return f;
  endfunction

  // Step to the drive point and present any flit due on ustrm at the next edge
  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
    exp_due = 1'b0;
    if (sb_q.size() > 0 && sb_q[0].cycle + LATENCY == cycle) begin
      exp_flit = sb_q[0].flit;
      exp_due  = 1'b1;
      sb_q.delete(0);
    end
  endtask

  task automatic wait_all_locked();
    while (tx_dbg[NUM_LANES-1:0] != '1) begin
      next_cycle();
    end
  endtask

  // Back-to-back random flits, then drain the scoreboard
  task automatic send_traffic(input int count);
    for (int i = 0; i < count; i++) begin
      next_cycle();
      drv_flit = random_flit();
      sb_q.push_back('{flit: drv_flit, cycle: cycle});
    end
    next_cycle();
    drv_flit = '0;
    while (sb_q.size() > 0) begin
      next_cycle();
    end
    next_cycle();
  endtask

  // Random flits while a link direction is down, nothing expected on ustrm
  task automatic send_unchecked(input int count);
    for (int i = 0; i < count; i++) begin
      next_cycle();
      drv_flit = random_flit();
    end
  endtask

  initial begin
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk_wr);
    end
    $display("Timeout: the run did not complete within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    rst_n         = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = DELAY_W'(DX);
    delay_y_value = DELAY_W'(DY);
    delay_z_value = DELAY_W'(DZ);
    drv_flit      = '0;
    exp_flit      = '0;
    exp_due       = 1'b0;
    void'($urandom(32'hd36c));

    repeat (4) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;

    // Idle link, then bring both directions up
    send_unchecked(10);
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_all_locked();
    repeat (4 * (DZ + 1)) next_cycle();
    send_traffic(400);

    // Upstream drop and relock
    rx_online = 1'b0;
    send_unchecked(20);
    rx_online = 1'b1;
    wait_all_locked();
    send_traffic(100);

    tx_online = 1'b0;
    send_unchecked(20);

    $display("Checks done: %0d value errors, %0d sequence errors", value_errors, seq_errors);
    if (value_errors == 0 && seq_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/tb_lpif_checks.sv ====
`timescale 1ns/100ps

module tb_lpif_checks
  import lpif_pkg::*;
#(
  parameter int NUM_LANES = 4,
  parameter int DX        = 5,
  parameter int DY        = 3,
  parameter int DZ        = 7
) (
  input  logic                             clk_wr,
  input  logic                             rst_n,
  input  logic                             tx_online,
  input  logic                             rx_online,
  input  logic [NUM_LANES-1:0][LANE_W-1:0] tx_phy,
  input  lpif_flit_t                       ustrm_flit,
  input  logic [31:0]                      tx_dbg,
  input  logic [31:0]                      rx_dbg,
  input  logic                             exp_due,
  input  lpif_flit_t                       exp_flit,
  output int                               value_errors,
  output int                               seq_errors
);

  logic                 tx_on_d;
  logic                 rx_on_d;
  logic                 online_seen_q;
  logic                 pre_online;
  logic [NUM_LANES-1:0] lock;
  logic [NUM_LANES-1:0] stb_vec;

  initial begin
    value_errors = 0;
    seq_errors   = 0;
  end

  task automatic value_error(input string name, input string expected, input string actual);
    value_errors++;
    $display("error %s expected %s got %s", name, expected, actual);
  endtask

  task automatic timing_error(input string what);
    seq_errors++;
    $display("Sequence check failed at %0t: %s", $time, what);
  endtask

  // Delayed online levels are only visible through the debug word
  assign tx_on_d = tx_dbg[19];
  assign rx_on_d = tx_dbg[18];
  assign lock    = tx_dbg[NUM_LANES-1:0];

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_stb
    assign stb_vec[i] = tx_phy[i][STB_BIT];
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      online_seen_q <= 1'b0;
    end else if (tx_on_d) begin
      online_seen_q <= 1'b1;
    end
  end

  assign pre_online = !online_seen_q && !tx_on_d;

  //////////////////////////////////////////////////////////////////////
  // Bring-up and debug word

  a_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    pre_online |-> (tx_phy == '0) && !ustrm_flit.valid && ((tx_dbg & 32'h0008_000f) == '0))
    else value_error("tx_phy/ustrm_valid/debug before online", "0",
                     $sformatf("%h/%h/%h", $sampled(tx_phy), $sampled(ustrm_flit.valid),
                               $sampled(tx_dbg)));

  a_dbg_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (tx_dbg & 32'hfff3_fff0) == '0)
    else value_error("tx_downstream_debug_status",
                     $sformatf("%h", $sampled(tx_dbg) & 32'h000c_000f),
                     $sformatf("%h", $sampled(tx_dbg)));

  a_dbg_layout: assert property (@(posedge clk_wr) disable iff (!rst_n)
    rx_dbg == tx_dbg)
    else value_error("rx_upstream_debug_status", $sformatf("%h", $sampled(tx_dbg)),
                     $sformatf("%h", $sampled(rx_dbg)));

  a_tx_rise: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $rose(tx_online) |-> (!tx_on_d) [*(DX+1)] ##1 tx_on_d)
    else timing_error("tx online level did not rise delay_x_value+1 cycles after tx_online");

  a_rx_rise: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $rose(rx_online) |-> (!rx_on_d) [*(DY+1)] ##1 rx_on_d)
    else timing_error("rx online level did not rise delay_y_value+1 cycles after rx_online");

  //////////////////////////////////////////////////////////////////////
  // Strobe on the PHY words

  a_stb_first: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $rose(tx_on_d) |-> ##2 stb_vec[0])
    else timing_error("first tx strobe missing two cycles after tx went online");

  a_stb_period: assert property (@(posedge clk_wr) disable iff (!rst_n || !tx_online)
    stb_vec[0] |-> ##1 (!stb_vec[0]) [*DZ] ##1 stb_vec[0])
    else timing_error("tx strobe period differs from delay_z_value+1 cycles");

  a_stb_lanes: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (stb_vec == '0) || (stb_vec == '1))
    else value_error("tx_phy strobe bits",
                     $sformatf("%h", {NUM_LANES{$sampled(stb_vec[0])}}),
                     $sformatf("%h", $sampled(stb_vec)));

  //////////////////////////////////////////////////////////////////////
  // Flit transport and link drop

  a_flit: assert property (@(posedge clk_wr) disable iff (!rst_n)
    exp_due |-> (ustrm_flit == exp_flit))
    else value_error("ustrm_flit", $sformatf("%h", $sampled(exp_flit)),
                     $sformatf("%h", $sampled(ustrm_flit)));

  a_unlocked: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (lock != '1) |=> (ustrm_flit == '0))
    else value_error("ustrm_flit", "0", $sformatf("%h", $sampled(ustrm_flit)));

  a_lock_drop: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $fell(rx_on_d) |=> (lock == '0))
    else timing_error("lane locks still set one cycle after rx went offline");

  // Two register stages between the online level and tx_phy
  a_tx_offline: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !$past(tx_on_d, 2) |-> (tx_phy == '0))
    else value_error("tx_phy", "0", $sformatf("%h", $sampled(tx_phy)));

endmodule

// ==== rtl/lpif_bridge_top.sv ====
`timescale 1ns/100ps

module lpif_bridge_top
  import lpif_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic                              clk_wr,
  input  logic                              rst_n,

  // Link control
  input  logic                              tx_online,
  input  logic                              rx_online,
  input  logic [DELAY_W-1:0]                delay_x_value,
  input  logic [DELAY_W-1:0]                delay_y_value,
  input  logic [DELAY_W-1:0]                delay_z_value,

  // PHY lanes
  output logic [NUM_LANES-1:0][LANE_W-1:0]  tx_phy,
  input  logic [NUM_LANES-1:0][LANE_W-1:0]  rx_phy,

  // Downstream flit
  input  logic [STATE_W-1:0]                dstrm_state,
  input  logic [PROTID_W-1:0]               dstrm_protid,
  input  logic [DATA_W-1:0]                 dstrm_data,
  input  logic                              dstrm_dvalid,
  input  logic [CRC_W-1:0]                  dstrm_crc,
  input  logic                              dstrm_crc_valid,
  input  logic                              dstrm_valid,

  // Upstream flit
  output logic [STATE_W-1:0]                ustrm_state,
  output logic [PROTID_W-1:0]               ustrm_protid,
  output logic [DATA_W-1:0]                 ustrm_data,
  output logic                              ustrm_dvalid,
  output logic [CRC_W-1:0]                  ustrm_crc,
  output logic                              ustrm_crc_valid,
  output logic                              ustrm_valid,

  output logic [31:0]                       tx_downstream_debug_status,
  output logic [31:0]                       rx_upstream_debug_status
);

  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       stb_pulse;
  lpif_flit_t dstrm_flit;
  lpif_flit_t ustrm_flit;

  lane_if lanes [NUM_LANES] ();

  //////////////////////////////////////////////////////////////////////
  // Flit field mapping

  assign dstrm_flit = '{state:     dstrm_state,
                        protid:    dstrm_protid,
                        data:      dstrm_data,
                        dvalid:    dstrm_dvalid,
                        crc:       dstrm_crc,
                        crc_valid: dstrm_crc_valid,
                        valid:     dstrm_valid};

  assign ustrm_state     = ustrm_flit.state;
  assign ustrm_protid    = ustrm_flit.protid;
  assign ustrm_data      = ustrm_flit.data;
  assign ustrm_dvalid    = ustrm_flit.dvalid;
  assign ustrm_crc       = ustrm_flit.crc;
  assign ustrm_crc_valid = ustrm_flit.crc_valid;
  assign ustrm_valid     = ustrm_flit.valid;

  //////////////////////////////////////////////////////////////////////
  // Link sync, packer, lanes, unpacker

  link_sync u_link_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .stb_pulse       (stb_pulse)
  );

  flit_pack #(.NUM_LANES(NUM_LANES)) u_flit_pack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .stb_pulse       (stb_pulse),
    .dstrm_flit      (dstrm_flit),
    .lanes           (lanes)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    phy_lane #(.LANE_IDX(i)) u_phy_lane (
      .clk_wr          (clk_wr),
      .rst_n           (rst_n),
      .rx_online_delay (rx_online_delay),
      .lane            (lanes[i]),
      .tx_phy          (tx_phy[i]),
      .rx_phy          (rx_phy[i])
    );
  end

  flit_unpack #(.NUM_LANES(NUM_LANES)) u_flit_unpack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .lanes           (lanes),
    .ustrm_flit      (ustrm_flit),
    .tx_debug_status (tx_downstream_debug_status),
    .rx_debug_status (rx_upstream_debug_status)
  );

endmodule

// ==== rtl/flit_unpack.sv ====
`timescale 1ns/100ps

module flit_unpack
  import lpif_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic        clk_wr,
  input  logic        rst_n,

  input  logic        tx_online_delay,
  input  logic        rx_online_delay,

  lane_if.unpack      lanes [NUM_LANES],

  output lpif_flit_t  ustrm_flit,

  output logic [31:0] tx_debug_status,
  output logic [31:0] rx_debug_status
);

  localparam int PAD_W = NUM_LANES * LANE_PAYLOAD_W;

  logic [PAD_W-1:0]      rx_cat;
  logic [NUM_LANES-1:0]  locked_vec;
  logic [NUM_LANES-1:0]  stb_vec;
  logic                  all_locked;
  logic [DBG_LOCK_W-1:0] lock_dbg;

  //////////////////////////////////////////////////////////////////////
  // Lane gather

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_gather
    assign rx_cat[i*LANE_PAYLOAD_W +: LANE_PAYLOAD_W] = lanes[i].rx_payload;
    assign locked_vec[i] = lanes[i].locked;
    assign stb_vec[i]    = lanes[i].rx_stb;
  end

  assign all_locked = &locked_vec;

  // Upper padding bits fall away here
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      ustrm_flit <= '0;
    end else begin
      ustrm_flit <= all_locked ? lpif_flit_t'(rx_cat[FLIT_W-1:0]) : '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Debug status

  assign lock_dbg = DBG_LOCK_W'(locked_vec);

  assign tx_debug_status = {12'h0, tx_online_delay, rx_online_delay, 14'h0, lock_dbg};
  assign rx_debug_status = {12'h0, tx_online_delay, rx_online_delay, 14'h0, lock_dbg};

  // Locked lanes see the strobe on the same capture
  a_stb_aligned: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
      ((stb_vec & locked_vec) == '0) || ((stb_vec & locked_vec) == locked_vec)
  ) else $error("flit_unpack: rx strobes differ across locked lanes, stb=%h lock=%h",
                stb_vec, locked_vec);

endmodule

// ==== rtl/phy_lane.sv ====
`timescale 1ns/100ps

module phy_lane
  import lpif_pkg::*;
#(
  parameter int LANE_IDX = 0
) (
  input  logic              clk_wr,
  input  logic              rst_n,

  input  logic              rx_online_delay,

  lane_if.lane              lane,

  output logic [LANE_W-1:0] tx_phy,
  input  logic [LANE_W-1:0] rx_phy
);

  logic [LANE_PAYLOAD_W-1:0] rx_payload_q;
  logic                      rx_stb_q;
  logic                      locked_q;

  //////////////////////////////////////////////////////////////////////
  // Transmit word

  // Strobe rides in the top bit
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= {lane.tx_stb, lane.tx_payload};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive capture and lock

  always_ff @(posedge clk_wr) begin
    rx_payload_q <= rx_phy[LANE_PAYLOAD_W-1:0];
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_stb_q <= 1'b0;
      locked_q <= 1'b0;
    end else begin
      rx_stb_q <= rx_phy[STB_BIT];
      // Lock on the first strobe once rx is online, drop with it
      if (!rx_online_delay) begin
        locked_q <= 1'b0;
      end else if (rx_phy[STB_BIT]) begin
        locked_q <= 1'b1;
      end
    end
  end

  assign lane.rx_payload = rx_payload_q;
  assign lane.rx_stb     = rx_stb_q;
  assign lane.locked     = locked_q;

  a_lock_on_stb: assert property (
    @(posedge clk_wr) disable iff (!rst_n) $rose(locked_q) |-> rx_stb_q
  ) else $error("phy_lane %0d: lock rose without an rx strobe", LANE_IDX);

endmodule

// ==== rtl/flit_pack.sv ====
`timescale 1ns/100ps

module flit_pack
  import lpif_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic       clk_wr,
  input  logic       rst_n,

  input  logic       tx_online_delay,
  input  logic       stb_pulse,

  input  lpif_flit_t dstrm_flit,

  lane_if.pack       lanes [NUM_LANES]
);

  localparam int PAD_W = NUM_LANES * LANE_PAYLOAD_W;

  // Lane budget has to hold the whole flit
  if (PAD_W < FLIT_W) begin : g_budget_check
    $error("flit_pack: %0d lanes cannot carry a %0d bit flit", NUM_LANES, FLIT_W);
  end

  logic [PAD_W-1:0] flit_q;
  logic             stb_q;

  //////////////////////////////////////////////////////////////////////
  // Flit register, zero while offline

  always_ff @(posedge clk_wr) begin
    flit_q <= tx_online_delay ? PAD_W'(dstrm_flit) : '0;
  end

  // Strobe follows the payload through one stage
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      stb_q <= 1'b0;
    end else begin
      stb_q <= stb_pulse & tx_online_delay;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lane slicing, lane 0 gets the low bits

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_slice
    assign lanes[i].tx_payload = flit_q[i*LANE_PAYLOAD_W +: LANE_PAYLOAD_W];
    assign lanes[i].tx_stb     = stb_q;
  end

endmodule

// ==== rtl/link_sync.sv ====
`timescale 1ns/100ps

module link_sync
  import lpif_pkg::*;
(
  input  logic               clk_wr,
  input  logic               rst_n,

  input  logic               tx_online,
  input  logic               rx_online,

  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,

  output logic               tx_online_delay,
  output logic               rx_online_delay,
  output logic               stb_pulse
);

  localparam int TX = 0;
  localparam int RX = 1;

  logic [1:0]              online_in;
  logic [1:0][DELAY_W-1:0] delay_val;
  logic [1:0][DELAY_W-1:0] hold_cnt;
  logic [1:0]              online_q;
  logic                    tx_arrive;
  logic [DELAY_W-1:0]      period_cnt;

  //////////////////////////////////////////////////////////////////////
  // Online hold-off, same counter for both directions

  assign online_in      = {rx_online, tx_online};
  assign delay_val[TX]  = delay_x_value;
  assign delay_val[RX]  = delay_y_value;

  // Count up to the programmed delay and saturate there
  always_ff @(posedge clk_wr) begin
    for (int k = 0; k < 2; k++) begin
      if (!rst_n || !online_in[k]) begin
        hold_cnt[k] <= '0;
        online_q[k] <= 1'b0;
      end else if (hold_cnt[k] >= delay_val[k]) begin
        online_q[k] <= 1'b1;
      end else begin
        hold_cnt[k] <= hold_cnt[k] + 1'b1;
      end
    end
  end

  assign tx_online_delay = online_q[TX];
  assign rx_online_delay = online_q[RX];

  //////////////////////////////////////////////////////////////////////
  // Periodic strobe

  // Edge on which tx_online_delay is about to rise
  assign tx_arrive = tx_online && !online_q[TX] && (hold_cnt[TX] >= delay_x_value);

  // First pulse lines up with the first online cycle
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online) begin
      period_cnt <= '0;
      stb_pulse  <= 1'b0;
    end else if (tx_arrive) begin
      period_cnt <= '0;
      stb_pulse  <= 1'b1;
    end else if (online_q[TX] && (period_cnt >= delay_z_value)) begin
      period_cnt <= '0;
      stb_pulse  <= 1'b1;
    end else if (online_q[TX]) begin
      period_cnt <= period_cnt + 1'b1;
      stb_pulse  <= 1'b0;
    end else begin
      stb_pulse  <= 1'b0;
    end
  end

  a_stb_only_online: assert property (
    @(posedge clk_wr) disable iff (!rst_n) stb_pulse |-> tx_online_delay
  ) else $error("link_sync: stb_pulse high while tx_online_delay is low");

endmodule

// ==== rtl/lane_if.sv ====
`timescale 1ns/100ps

// One PHY lane worth of payload, strobe and lock
interface lane_if
  import lpif_pkg::*;
();

  // Downstream side, from the packer
  logic [LANE_PAYLOAD_W-1:0] tx_payload;
  logic                      tx_stb;

  // Upstream side, towards the unpacker
  logic [LANE_PAYLOAD_W-1:0] rx_payload;
  logic                      rx_stb;
  logic                      locked;

  modport pack (
    output tx_payload,
    output tx_stb
  );

  modport lane (
    input  tx_payload,
    input  tx_stb,
    output rx_payload,
    output rx_stb,
    output locked
  );

  modport unpack (
    input  rx_payload,
    input  rx_stb,
    input  locked
  );

endinterface

// ==== rtl/lpif_pkg.sv ====
package lpif_pkg;

  ////////////////////////////////////////////////////////////////////
  // PHY lane geometry

  localparam int LANE_W         = 40;
  // Top bit of every lane word carries the strobe
  localparam int LANE_PAYLOAD_W = LANE_W - 1;
  localparam int STB_BIT        = LANE_W - 1;

  ////////////////////////////////////////////////////////////////////
  // Flit field widths

  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 128;
  localparam int CRC_W    = 16;

  // Online delay and strobe period programming
  localparam int DELAY_W = 16;

  // Link-layer flit, valid in bit 0
  typedef struct packed {
    logic [STATE_W-1:0]  state;
    logic [PROTID_W-1:0] protid;
    logic [DATA_W-1:0]   data;
    logic                dvalid;
    logic [CRC_W-1:0]    crc;
    logic                crc_valid;
    logic                valid;
  } lpif_flit_t;

  localparam int FLIT_W = $bits(lpif_flit_t);

  // Width of the debug lock field
  localparam int DBG_LOCK_W = 4;

endpackage
